/* common/alu_pkg.sv */
package alu_pkg;

  localparam int XLEN      = 32;
  localparam int SHAMT_W   = 5;
  localparam int PAGE_BITS = 12;
  localparam int CNT_W     = 6;

  typedef enum logic [4:0] {
    OP_ADD,
    OP_SUB,
    OP_SLT,
    OP_SLTU,
    OP_LSA,
    OP_PCALAU,
    OP_LU12I,
    OP_AND,
    OP_ANDN,
    OP_OR,
    OP_ORN,
    OP_XOR,
    OP_NOR,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_ROT,
    OP_COUNT_L,
    OP_COUNT_T,
    OP_BITREV,
    OP_REVB,
    OP_SEB,
    OP_SEH,
    OP_SELEQZ,
    OP_SELNEZ
  } alu_op_e;

  // execution unit that produces the result
  typedef enum logic [1:0] {
    UNIT_ADD,
    UNIT_SHIFT,
    UNIT_BITS
  } unit_e;

  typedef struct packed {
    alu_op_e         op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [1:0]      aux;
  } alu_req_t;

  typedef struct packed {
    alu_op_e         op;
    unit_e           unit;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [1:0]      aux;
  } alu_stage_t;

  typedef struct packed {
    logic [XLEN-1:0] result;
    logic            zero;
  } alu_resp_t;

endpackage

/* bitops/leading_counter.sv */
`timescale 1ns/100ps

module leading_counter #(
  parameter int WIDTH = 32
) (
  input  logic [WIDTH-1:0]       value,
  input  logic                   count_ones,
  output logic [$clog2(WIDTH):0] count
);

  localparam int CW = $clog2(WIDTH) + 1;

  generate
    if (WIDTH == 4) begin : g_leaf
      logic [3:0] bits;

      // count ones of the possibly inverted nibble
      assign bits = count_ones ? value : ~value;

      always_comb begin
        if (&bits) begin
          count = 3'd4;
        end else if (&bits[3:1]) begin
          count = 3'd3;
        end else if (&bits[3:2]) begin
          count = 3'd2;
        end else if (bits[3]) begin
          count = 3'd1;
        end else begin
          count = 3'd0;
        end
      end
    end else begin : g_split
      logic [CW-2:0] cnt_hi;
      logic [CW-2:0] cnt_lo;

      leading_counter #(.WIDTH(WIDTH / 2)) u_hi (
        .value      (value[WIDTH-1:WIDTH/2]),
        .count_ones (count_ones),
        .count      (cnt_hi)
      );

      leading_counter #(.WIDTH(WIDTH / 2)) u_lo (
        .value      (value[WIDTH/2-1:0]),
        .count_ones (count_ones),
        .count      (cnt_lo)
      );

      // msb of cnt_hi set only when the high half is saturated
      assign count = cnt_hi[CW-2] ? ({1'b0, cnt_hi} + {1'b0, cnt_lo}) : {1'b0, cnt_hi};
    end
  endgenerate

endmodule

/* bitops/alu_bitops.sv */
`timescale 1ns/100ps

module alu_bitops (
  input  alu_pkg::alu_stage_t       stage,
  output logic [alu_pkg::XLEN-1:0]  bits_res
);

  localparam int XLEN = alu_pkg::XLEN;

  logic [XLEN-1:0]          a;
  logic [XLEN-1:0]          b;
  logic [XLEN-1:0]          bitrev;
  logic [XLEN-1:0]          revb;
  logic [XLEN-1:0]          cnt_in;
  logic [alu_pkg::CNT_W-1:0] cnt;
  logic                     b_zero;

  assign a = stage.a;
  assign b = stage.b;

  always_comb begin
    for (int i = 0; i < XLEN; i++) begin
      bitrev[i] = a[XLEN-1-i];
    end
  end

  always_comb begin
    for (int i = 0; i < XLEN / 8; i++) begin
      revb[8*i +: 8] = a[XLEN-8-8*i +: 8];
    end
  end

  // trailing count is a leading count of the reversed word
  assign cnt_in = (stage.op == alu_pkg::OP_COUNT_T) ? bitrev : a;

  leading_counter #(
    .WIDTH (XLEN)
  ) u_counter (
    .value      (cnt_in),
    .count_ones (stage.aux[0]),
    .count      (cnt)
  );

  assign b_zero = (b == '0);

  always_comb begin
    case (stage.op)
      alu_pkg::OP_AND:     bits_res = a & b;
      alu_pkg::OP_ANDN:    bits_res = a & ~b;
      alu_pkg::OP_OR:      bits_res = a | b;
      alu_pkg::OP_ORN:     bits_res = a | ~b;
      alu_pkg::OP_XOR:     bits_res = a ^ b;
      alu_pkg::OP_NOR:     bits_res = ~(a | b);
      alu_pkg::OP_LU12I:   bits_res = b;
      alu_pkg::OP_COUNT_L,
      alu_pkg::OP_COUNT_T: bits_res = {{(XLEN-alu_pkg::CNT_W){1'b0}}, cnt};
      alu_pkg::OP_BITREV:  bits_res = bitrev;
      alu_pkg::OP_REVB:    bits_res = revb;
      alu_pkg::OP_SEB:     bits_res = {{(XLEN-8){a[7]}}, a[7:0]};
      alu_pkg::OP_SEH:     bits_res = {{(XLEN-16){a[15]}}, a[15:0]};
      alu_pkg::OP_SELEQZ:  bits_res = b_zero ? a : '0;
      alu_pkg::OP_SELNEZ:  bits_res = b_zero ? '0 : a;
      default:             bits_res = '0;
    endcase
  end

endmodule

/* source/alu_issue.sv */
`timescale 1ns/100ps

module alu_issue (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  input  alu_pkg::alu_req_t   req,
  output logic                stage_valid,
  output alu_pkg::alu_stage_t stage
);

  alu_pkg::unit_e unit;

  // opcode to execution unit
  always_comb begin
    case (req.op)
      alu_pkg::OP_ADD,
      alu_pkg::OP_SUB,
      alu_pkg::OP_SLT,
      alu_pkg::OP_SLTU,
      alu_pkg::OP_LSA,
      alu_pkg::OP_PCALAU: begin
        unit = alu_pkg::UNIT_ADD;
      end
      alu_pkg::OP_SLL,
      alu_pkg::OP_SRL,
      alu_pkg::OP_SRA,
      alu_pkg::OP_ROT: begin
        unit = alu_pkg::UNIT_SHIFT;
      end
      // logic, select, counts, rearrangement and lu12i
      default: begin
        unit = alu_pkg::UNIT_BITS;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stage_valid <= 1'b0;
    end else begin
      stage_valid <= in_valid;
    end
  end

  // payload only moves on a strobe
  always_ff @(posedge clk) begin
    if (in_valid) begin
      stage.op   <= req.op;
      stage.unit <= unit;
      stage.a    <= req.a;
      stage.b    <= req.b;
      stage.aux  <= req.aux;
    end
  end

endmodule

/* source/alu_adder.sv */
`timescale 1ns/100ps

module alu_adder (
  input  alu_pkg::alu_stage_t       stage,
  output logic [alu_pkg::XLEN-1:0]  add_res
);

  localparam int MSB = alu_pkg::XLEN - 1;

  logic            invb;
  logic [MSB:0]    addend;
  logic [2:0]      offset;
  logic [MSB:0]    a_in;
  logic [MSB:0]    sum;
  logic            cf;
  logic            of;
  logic            slt;
  logic            sltu;
  logic [MSB:0]    page_mask;

  // subtract-type ops add ~b + 1
  assign invb = stage.op inside {alu_pkg::OP_SUB, alu_pkg::OP_SLT, alu_pkg::OP_SLTU};
  assign addend = invb ? ~stage.b : stage.b;

  // lsa scales a by 2..16
  assign offset = {1'b0, stage.aux} + 3'd1;
  assign a_in = (stage.op == alu_pkg::OP_LSA) ? (stage.a << offset) : stage.a;

  assign {cf, sum} = {1'b0, a_in} + {1'b0, addend} + {{alu_pkg::XLEN{1'b0}}, invb};

  // carry into msb xor carry out
  assign of = a_in[MSB] ^ addend[MSB] ^ sum[MSB] ^ cf;
  assign slt = sum[MSB] ^ of;
  assign sltu = ~cf;

  assign page_mask = {{(alu_pkg::XLEN - alu_pkg::PAGE_BITS){1'b1}},
                      {alu_pkg::PAGE_BITS{1'b0}}};

  always_comb begin
    case (stage.op)
      alu_pkg::OP_SLT:    add_res = {{MSB{1'b0}}, slt};
      alu_pkg::OP_SLTU:   add_res = {{MSB{1'b0}}, sltu};
      alu_pkg::OP_PCALAU: add_res = sum & page_mask;
      default:            add_res = sum;
    endcase
  end

endmodule

/* source/alu_shifter.sv */
`timescale 1ns/100ps

module alu_shifter (
  input  alu_pkg::alu_stage_t       stage,
  output logic [alu_pkg::XLEN-1:0]  shift_res
);

  localparam int XLEN = alu_pkg::XLEN;

  logic [alu_pkg::SHAMT_W-1:0] shamt;
  logic                        fill;
  logic [XLEN-1:0]             sll_res;
  logic [2*XLEN-1:0]           sr_wide;
  logic [2*XLEN-1:0]           rot_wide;

  assign shamt = stage.b[alu_pkg::SHAMT_W-1:0];

  assign sll_res = stage.a << shamt;

  // single right shifter, sign fill only for sra
  assign fill = (stage.op == alu_pkg::OP_SRA) & stage.a[XLEN-1];
  assign sr_wide = {{XLEN{fill}}, stage.a} >> shamt;

  // rotate right: low bits wrap in from the copy above
  assign rot_wide = {stage.a, stage.a} >> shamt;

  always_comb begin
    case (stage.op)
      alu_pkg::OP_SLL: begin
        shift_res = sll_res;
      end
      alu_pkg::OP_SRL,
      alu_pkg::OP_SRA: begin
        shift_res = sr_wide[XLEN-1:0];
      end
      alu_pkg::OP_ROT: begin
        shift_res = rot_wide[XLEN-1:0];
      end
      default: begin
        shift_res = '0;
      end
    endcase
  end

endmodule

/* source/alu_writeback.sv */
`timescale 1ns/100ps

module alu_writeback (
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     stage_valid,
  input  alu_pkg::unit_e           unit,
  input  logic [alu_pkg::XLEN-1:0] add_res,
  input  logic [alu_pkg::XLEN-1:0] shift_res,
  input  logic [alu_pkg::XLEN-1:0] bits_res,
  output logic                     out_valid,
  output alu_pkg::alu_resp_t       resp
);

  logic [alu_pkg::XLEN-1:0] result;

  // unit was decoded at issue
  always_comb begin
    case (unit)
      alu_pkg::UNIT_ADD: begin
        result = add_res;
      end
      alu_pkg::UNIT_SHIFT: begin
        result = shift_res;
      end
      default: begin
        result = bits_res;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= stage_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (stage_valid) begin
      resp.result <= result;
      resp.zero   <= (result == '0);
    end
  end

endmodule

/* source/alu_top.sv */
`timescale 1ns/100ps

module alu_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              in_valid,
  input  alu_pkg::alu_req_t req,
  output logic              out_valid,
  output alu_pkg::alu_resp_t resp
);

  logic                      stage_valid;
  alu_pkg::alu_stage_t       stage;
  logic [alu_pkg::XLEN-1:0]  add_res;
  logic [alu_pkg::XLEN-1:0]  shift_res;
  logic [alu_pkg::XLEN-1:0]  bits_res;

  // stage 1: capture and classify
  alu_issue u_issue (
    .clk         (clk),
    .rst_n       (rst_n),
    .in_valid    (in_valid),
    .req         (req),
    .stage_valid (stage_valid),
    .stage       (stage)
  );

  alu_adder u_adder (
    .stage   (stage),
    .add_res (add_res)
  );

  alu_shifter u_shifter (
    .stage     (stage),
    .shift_res (shift_res)
  );

  alu_bitops u_bitops (
    .stage    (stage),
    .bits_res (bits_res)
  );

  // stage 2: pick and register
  alu_writeback u_writeback (
    .clk         (clk),
    .rst_n       (rst_n),
    .stage_valid (stage_valid),
    .unit        (stage.unit),
    .add_res     (add_res),
    .shift_res   (shift_res),
    .bits_res    (bits_res),
    .out_valid   (out_valid),
    .resp        (resp)
  );

endmodule

/* sim/alu_model.svh */
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// galois form of x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  if (state[0]) begin
    return (state >> 1) ^ 32'h8020_0003;
  end
  return state >> 1;
endfunction

// run length of equal bits from one end of the word
function automatic logic [alu_pkg::XLEN-1:0] count_run(input logic [alu_pkg::XLEN-1:0] v,
                                                       input logic ones,
                                                       input logic from_msb);
  int n;
  int idx;
  n = 0;
  for (int i = 0; i < alu_pkg::XLEN; i++) begin
    idx = from_msb ? alu_pkg::XLEN - 1 - i : i;
    if (v[idx] != ones) begin
      break;
    end
    n++;
  end
  return n;
endfunction

function automatic alu_pkg::alu_resp_t model_resp(input alu_pkg::alu_req_t r);
  logic [alu_pkg::XLEN-1:0] a;
  logic [alu_pkg::XLEN-1:0] b;
  logic [alu_pkg::XLEN-1:0] y;
  int sh;
  alu_pkg::alu_resp_t rsp;
  a = r.a;
  b = r.b;
  sh = b[alu_pkg::SHAMT_W-1:0];
  y = '0;
  case (r.op)
    alu_pkg::OP_ADD:     y = a + b;
    alu_pkg::OP_SUB:     y = a - b;
    alu_pkg::OP_SLT:     y = ($signed(a) < $signed(b)) ? 1 : 0;
    alu_pkg::OP_SLTU:    y = (a < b) ? 1 : 0;
    alu_pkg::OP_LSA:     y = (a << (int'(r.aux) + 1)) + b;
    alu_pkg::OP_PCALAU: begin
      y = a + b;
      y[alu_pkg::PAGE_BITS-1:0] = '0;
    end
    alu_pkg::OP_LU12I:   y = b;
    alu_pkg::OP_AND:     y = a & b;
    alu_pkg::OP_ANDN:    y = a & ~b;
    alu_pkg::OP_OR:      y = a | b;
    alu_pkg::OP_ORN:     y = a | ~b;
    alu_pkg::OP_XOR:     y = a ^ b;
    alu_pkg::OP_NOR:     y = ~(a | b);
    alu_pkg::OP_SLL:     y = a << sh;
    alu_pkg::OP_SRL:     y = a >> sh;
    alu_pkg::OP_SRA:     y = $signed(a) >>> sh;
    alu_pkg::OP_ROT:     y = (sh == 0) ? a : ((a >> sh) | (a << (alu_pkg::XLEN - sh)));
    alu_pkg::OP_COUNT_L: y = count_run(a, r.aux[0], 1'b1);
    alu_pkg::OP_COUNT_T: y = count_run(a, r.aux[0], 1'b0);
    alu_pkg::OP_BITREV:  y = {<<{a}};
    alu_pkg::OP_REVB:    y = {<<8{a}};
    alu_pkg::OP_SEB:     y = $signed(a[7:0]);
    alu_pkg::OP_SEH:     y = $signed(a[15:0]);
    alu_pkg::OP_SELEQZ:  y = (b == '0) ? a : '0;
    alu_pkg::OP_SELNEZ:  y = (b == '0) ? '0 : a;
    default:             y = '0;
  endcase
  rsp.result = y;
  rsp.zero = (y == '0);
  return rsp;
endfunction

`endif

/* sim/alu_tb.sv */
`timescale 1ns/100ps

module alu_tb;

  localparam int XLEN = alu_pkg::XLEN;
  localparam int RAND_N = 8;
  localparam int GAP_N = 16;
  localparam int NUM_OPS = alu_pkg::OP_SELNEZ + 1;
  // requests per section, in the order they are sent
  localparam int NUM_REQ = 4 * (RAND_N + 3) + 8 + 2 * RAND_N + 6 * RAND_N + 9
                           + 4 * (RAND_N + 2) + RAND_N + 4 * (RAND_N + 2) + 4 * XLEN
                           + 4 * RAND_N + GAP_N;
  // gaps add at most four idle cycles each
  localparam int LIMIT_NS = (NUM_REQ + 4 * GAP_N + 20) * 100;

  logic               clk;
  logic               rst_n;
  logic               in_valid;
  alu_pkg::alu_req_t  req;
  logic               out_valid;
  alu_pkg::alu_resp_t resp;

  logic [31:0]        lfsr_state = 32'h9b35;
  int                 cycle;
  int                 errors;
  alu_pkg::alu_resp_t exp_q[$];
  int                 due_q[$];
  alu_pkg::alu_resp_t exp_head;
  int                 exp_due;
  int                 exp_pending;
  logic               due_now;

  `include "alu_model.svh"

  alu_top DUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .req       (req),
    .out_valid (out_valid),
    .resp      (resp)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  assign due_now = (exp_pending > 0) && (cycle == exp_due);

  function automatic logic [XLEN-1:0] take_bits(input int n);
    logic [XLEN-1:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[XLEN-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  task automatic fail_value(input string name, input logic [32:0] expected,
                            input logic [32:0] actual);
    errors++;
    $display("ERROR: %s expected %h got %h", name, expected, actual);
    $display("TESTS FAILED");
    $fatal(1, "stopped at first mismatch");
  endtask

  task automatic refresh_head();
    exp_pending = exp_q.size();
    if (exp_pending > 0) begin
      exp_head = exp_q[0];
      exp_due = due_q[0];
    end
  endtask

  task automatic issue_request(input alu_pkg::alu_op_e op, input logic [XLEN-1:0] a,
                               input logic [XLEN-1:0] b, input logic [1:0] aux);
    alu_pkg::alu_req_t r;
    r.op = op;
    r.a = a;
    r.b = b;
    r.aux = aux;
    @(posedge clk);
    req <= r;
    in_valid <= 1'b1;
    exp_q.push_back(model_resp(r));
    // taken at the next edge, response sampled two edges after that
    due_q.push_back(cycle + 3);
    refresh_head();
  endtask

  task automatic hold_idle(input int n);
    repeat (n) begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  always @(posedge clk) begin
    if (rst_n && out_valid === 1'b1 && exp_q.size() > 0) begin
      void'(exp_q.pop_front());
      void'(due_q.pop_front());
      refresh_head();
    end
  end

  assert property (@(posedge clk) (cycle > 0 && !rst_n) |-> !out_valid)
    else fail_value("out_valid", 33'd0, {32'd0, $sampled(out_valid)});

  // strobe exactly two cycles after each request
  assert property (@(posedge clk) disable iff (!rst_n) out_valid == due_now)
    else fail_value("out_valid", {32'd0, $sampled(due_now)}, {32'd0, $sampled(out_valid)});

  assert property (@(posedge clk) disable iff (!rst_n) out_valid |-> resp == exp_head)
    else fail_value("resp", $sampled(exp_head), $sampled(resp));

  initial begin
    #(LIMIT_NS);
    $display("watchdog: responses did not arrive within %0d ns", LIMIT_NS);
    $display("TESTS FAILED");
    $fatal(1, "timeout");
  end

  initial begin
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    alu_pkg::alu_op_e cnt_op;
    rst_n = 1'b0;
    in_valid = 1'b0;
    req = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // arithmetic with overflow corners
    for (int op = alu_pkg::OP_ADD; op <= alu_pkg::OP_SLTU; op++) begin
      repeat (RAND_N) issue_request(alu_pkg::alu_op_e'(op), take_bits(XLEN), take_bits(XLEN), 0);
      issue_request(alu_pkg::alu_op_e'(op), 32'h7fff_ffff, 32'h8000_0000, 2'd0);
      issue_request(alu_pkg::alu_op_e'(op), 32'h8000_0000, 32'h7fff_ffff, 2'd0);
      a = take_bits(XLEN);
      issue_request(alu_pkg::alu_op_e'(op), a, a, 2'd0);
    end
    for (int k = 0; k < 4; k++) begin
      repeat (2) issue_request(alu_pkg::OP_LSA, take_bits(XLEN), take_bits(XLEN), 2'(k));
    end
    repeat (RAND_N) begin
      issue_request(alu_pkg::OP_PCALAU, take_bits(XLEN), take_bits(XLEN), 2'd0);
      issue_request(alu_pkg::OP_LU12I, take_bits(XLEN), take_bits(XLEN), 2'd0);
    end

    for (int op = alu_pkg::OP_AND; op <= alu_pkg::OP_NOR; op++) begin
      repeat (RAND_N) issue_request(alu_pkg::alu_op_e'(op), take_bits(XLEN), take_bits(XLEN), 0);
    end
    a = take_bits(XLEN);
    issue_request(alu_pkg::OP_XOR, a, a, 2'd0);
    repeat (2) begin
      a = take_bits(XLEN);
      b = take_bits(XLEN) | 32'd1;
      issue_request(alu_pkg::OP_SELEQZ, a, '0, 2'd0);
      issue_request(alu_pkg::OP_SELEQZ, a, b, 2'd0);
      issue_request(alu_pkg::OP_SELNEZ, a, '0, 2'd0);
      issue_request(alu_pkg::OP_SELNEZ, a, b, 2'd0);
    end

    for (int op = alu_pkg::OP_SLL; op <= alu_pkg::OP_ROT; op++) begin
      issue_request(alu_pkg::alu_op_e'(op), take_bits(XLEN), 32'd0, 2'd0);
      issue_request(alu_pkg::alu_op_e'(op), take_bits(XLEN), 32'd31, 2'd0);
      repeat (RAND_N) issue_request(alu_pkg::alu_op_e'(op), take_bits(XLEN), take_bits(XLEN), 0);
    end
    repeat (RAND_N) issue_request(alu_pkg::OP_SRA, take_bits(XLEN) | 32'h8000_0000,
                                  take_bits(XLEN), 2'd0);

    // odd k counts ones, so single-bit words are inverted
    for (int k = 0; k < 4; k++) begin
      cnt_op = (k < 2) ? alu_pkg::OP_COUNT_L : alu_pkg::OP_COUNT_T;
      issue_request(cnt_op, '0, '0, 2'(k));
      issue_request(cnt_op, '1, '0, 2'(k));
      repeat (RAND_N) issue_request(cnt_op, take_bits(XLEN), '0, 2'(k));
      for (int i = 0; i < XLEN; i++) begin
        a = XLEN'(1) << i;
        issue_request(cnt_op, k[0] ? ~a : a, '0, 2'(k));
      end
    end

    for (int op = alu_pkg::OP_BITREV; op <= alu_pkg::OP_SEH; op++) begin
      repeat (RAND_N) issue_request(alu_pkg::alu_op_e'(op), take_bits(XLEN), take_bits(XLEN), 0);
    end

    repeat (GAP_N) begin
      cnt_op = alu_pkg::alu_op_e'(take_bits(5) % NUM_OPS);
      issue_request(cnt_op, take_bits(XLEN), take_bits(XLEN), 2'(take_bits(2)));
      hold_idle(int'(take_bits(2)) + 1);
    end

    hold_idle(1);
    while (exp_q.size() != 0) @(posedge clk);
    repeat (2) @(posedge clk);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
+incdir+sim
common/alu_pkg.sv
bitops/leading_counter.sv
bitops/alu_bitops.sv
source/alu_issue.sv
source/alu_adder.sv
source/alu_shifter.sv
source/alu_writeback.sv
source/alu_top.sv
sim/alu_tb.sv

/* Bender.yml */
package:
  name: alu

sources:
  - files:
      - common/alu_pkg.sv
      - bitops/leading_counter.sv
      - bitops/alu_bitops.sv
      - source/alu_issue.sv
      - source/alu_adder.sv
      - source/alu_shifter.sv
      - source/alu_writeback.sv
      - source/alu_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/alu_tb.sv
